// ==== verilog/sram_pkg.sv ====
package sram_pkg;

  // active-low strobes on the asynchronous SRAM pins
  typedef struct packed {
    logic we_n;
    logic oe_n;
    logic ce_n;
  } sram_ctrl_t;

  // all strobes released, chip deselected
  localparam sram_ctrl_t sram_ctrl_idle = '{
    we_n: 1'b1,
    oe_n: 1'b1,
    ce_n: 1'b1
  };

  // direction of a single tester access
  typedef enum logic {
    access_read  = 1'b0,
    access_write = 1'b1
  } access_dir_e;

endpackage

// ==== verilog/tester_pkg.sv ====
package tester_pkg;

  // test order, first to last
  typedef enum logic [2:0] {
    pattern_zeros       = 3'd0,
    pattern_ones        = 3'd1,
    pattern_checker     = 3'd2,
    pattern_inv_checker = 3'd3,
    pattern_addr        = 3'd4,
    pattern_inv_addr    = 3'd5
  } pattern_kind_e;

  // sequencer states
  typedef enum logic [2:0] {
    state_start      = 3'd0,
    state_writing    = 3'd1,
    state_write_hold = 3'd2,
    state_reading    = 3'd3,
    state_read_hold  = 3'd4,
    state_done       = 3'd5,
    state_halt       = 3'd6
  } tester_state_e;

  typedef struct packed {
    logic          done;
    logic          pass;
    pattern_kind_e kind;
  } test_status_t;

endpackage

// ==== verilog/sram_controller.sv ====
`timescale 1ns/1ps

module sram_controller #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req,
  input  sram_pkg::access_dir_e  dir,
  input  logic [ADDR_BITS-1:0]   addr,
  input  logic [DATA_BITS-1:0]   write_data,
  output logic                   ready,
  output logic [DATA_BITS-1:0]   read_data,
  output logic [ADDR_BITS-1:0]   io_addr,
  inout  wire  [DATA_BITS-1:0]   io_data,
  output sram_pkg::sram_ctrl_t   io_ctrl
);

  import sram_pkg::*;

  localparam sram_ctrl_t write_strobe = '{we_n: 1'b0, oe_n: 1'b1, ce_n: 1'b0};
  localparam sram_ctrl_t read_strobe  = '{we_n: 1'b1, oe_n: 1'b0, ce_n: 1'b0};

  // high for the single cycle the pins are strobed
  logic                 strobe;
  logic [ADDR_BITS-1:0] addr_q;
  logic [DATA_BITS-1:0] write_q;

  // strobe sequencing
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      strobe  <= 1'b0;
      io_ctrl <= sram_ctrl_idle;
    end else if (strobe) begin
      strobe  <= 1'b0;
      io_ctrl <= sram_ctrl_idle;
    end else if (req) begin
      strobe  <= 1'b1;
      io_ctrl <= (dir == access_write) ? write_strobe : read_strobe;
    end
  end

  // request payload, held through the strobe
  always_ff @(posedge clk) begin
    if (req && !strobe) begin
      addr_q  <= addr;
      write_q <= write_data;
    end
  end

  // sample the bus as the read strobe ends
  always_ff @(posedge clk) begin
    if (strobe && !io_ctrl.oe_n) begin
      read_data <= io_data;
    end
  end

  assign ready   = strobe;
  assign io_addr = addr_q;

  // drive the bus only while writing
  assign io_data = io_ctrl.we_n ? {DATA_BITS{1'bz}} : write_q;

endmodule

// ==== verilog/pattern_generator.sv ====
`timescale 1ns/1ps

module pattern_generator #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      restart,
  input  logic                      advance,
  input  logic [ADDR_BITS-1:0]      addr,
  output logic [DATA_BITS-1:0]      data,
  output tester_pkg::pattern_kind_e kind,
  output logic                      last
);

  import tester_pkg::*;

  logic [DATA_BITS-1:0] base_word;
  logic                 invert;

  // current pattern kind
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      kind <= pattern_zeros;
    end else if (restart) begin
      kind <= pattern_zeros;
    end else if (advance) begin
      if (kind == pattern_inv_addr) begin
        kind <= pattern_zeros;
      end else begin
        kind <= pattern_kind_e'(kind + 3'd1);
      end
    end
  end

  // uninverted word for the kind, inverse kinds share it
  always_comb begin
    base_word = '0;
    invert    = 1'b0;
    case (kind)
      pattern_ones, pattern_inv_checker, pattern_inv_addr: invert = 1'b1;
      default: invert = 1'b0;
    endcase
    case (kind)
      pattern_checker, pattern_inv_checker: begin
        // odd bits set on even addresses, swapped on odd ones
        for (int i = 0; i < DATA_BITS; i++) begin
          base_word[i] = addr[0] ^ (i % 2 == 1);
        end
      end
      pattern_addr, pattern_inv_addr: base_word = DATA_BITS'(addr);
      default: base_word = '0;
    endcase
  end

  assign data = invert ? ~base_word : base_word;
  assign last = (kind == pattern_inv_addr);

endmodule

// ==== verilog/sram_tester.sv ====
`timescale 1ns/1ps

module sram_tester #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  logic                     clk,
  input  logic                     reset,
  output tester_pkg::test_status_t status,
  output logic [DATA_BITS-1:0]     prev_read_data,
  output logic [DATA_BITS-1:0]     prev_expected_data,
  output logic [ADDR_BITS-1:0]     io_addr,
  inout  wire  [DATA_BITS-1:0]     io_data,
  output sram_pkg::sram_ctrl_t     io_ctrl
);

  import sram_pkg::*;
  import tester_pkg::*;

  tester_state_e        state;
  tester_state_e        next_state;

  // controller side
  logic                 req;
  access_dir_e          dir;
  logic                 ready;
  logic [DATA_BITS-1:0] read_data;

  // pattern side
  logic                 restart;
  logic                 advance;
  logic [DATA_BITS-1:0] pattern_data;
  pattern_kind_e        kind;
  logic                 last_kind;

  logic [ADDR_BITS-1:0] addr;
  logic                 last_addr;
  logic [DATA_BITS-1:0] expected_q;

  // compare pipeline
  logic                 capture;
  logic                 validate;
  logic                 mismatch;
  logic                 pass_q;
  logic                 done_pending;
  logic                 done_q;

  sram_controller #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) sram_controller_i (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .dir       (dir),
    .addr      (addr),
    .write_data(pattern_data),
    .ready     (ready),
    .read_data (read_data),
    .io_addr   (io_addr),
    .io_data   (io_data),
    .io_ctrl   (io_ctrl)
  );

  pattern_generator #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) pattern_generator_i (
    .clk    (clk),
    .reset  (reset),
    .restart(restart),
    .advance(advance),
    .addr   (addr),
    .data   (pattern_data),
    .kind   (kind),
    .last   (last_kind)
  );

  assign mismatch  = validate && (prev_read_data != prev_expected_data);
  assign last_addr = (addr == {ADDR_BITS{1'b1}});

  // no new access once a failure is seen
  assign req = (state == state_writing || state == state_reading) && !mismatch;
  assign dir = (state == state_reading) ? access_read : access_write;

  always_comb begin
    next_state = state;
    advance    = 1'b0;
    restart    = 1'b0;
    case (state)
      state_start:      next_state = state_writing;
      state_writing:    next_state = state_write_hold;
      state_write_hold: begin
        if (ready) begin
          next_state = last_addr ? state_reading : state_writing;
        end
      end
      state_reading:    next_state = state_read_hold;
      state_read_hold: begin
        if (ready) begin
          if (!last_addr) begin
            next_state = state_reading;
          end else if (last_kind) begin
            next_state = state_done;
          end else begin
            next_state = state_start;
            advance    = 1'b1;
          end
        end
      end
      state_done: begin
        next_state = state_start;
        restart    = 1'b1;
      end
      state_halt:       next_state = state_halt;
      default:          next_state = state_start;
    endcase
    // freeze on the failing pattern
    if (mismatch) begin
      next_state = state_halt;
      advance    = 1'b0;
      restart    = 1'b0;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= state_start;
    end else begin
      state <= next_state;
    end
  end

  // address steps after each completed access
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      addr <= '0;
    end else if (state == state_start) begin
      addr <= '0;
    end else if ((state == state_write_hold || state == state_read_hold) && ready) begin
      addr <= addr + 1'b1;
    end
  end

  // expected word lines up with read_data one cycle after the strobe
  always_ff @(posedge clk) begin
    expected_q <= pattern_data;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      capture  <= 1'b0;
      validate <= 1'b0;
    end else begin
      capture  <= (state == state_read_hold) && ready;
      validate <= capture && (state != state_halt);
    end
  end

  // first failing word stays on the debug outputs
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      prev_read_data     <= '0;
      prev_expected_data <= '0;
    end else if (capture && state != state_halt) begin
      prev_read_data     <= read_data;
      prev_expected_data <= expected_q;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pass_q <= 1'b1;
    end else if (mismatch) begin
      pass_q <= 1'b0;
    end
  end

  // held back until the final word of the run has been compared
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      done_pending <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      done_pending <= (state == state_done);
      done_q       <= done_pending && !mismatch;
    end
  end

  assign status = '{done: done_q, pass: pass_q, kind: kind};

endmodule

// ==== tests/sram_model.sv ====
`timescale 1ns/1ps

module sram_model #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  logic [ADDR_BITS-1:0]         io_addr,
  inout  wire  [DATA_BITS-1:0]         io_data,
  input  sram_pkg::sram_ctrl_t         io_ctrl,
  input  logic                         fault_en,
  input  logic [ADDR_BITS-1:0]         fault_addr,
  input  logic [$clog2(DATA_BITS)-1:0] fault_bit,
  input  logic                         fault_value
);

  import sram_pkg::*;

  logic [DATA_BITS-1:0] mem [2**ADDR_BITS];
  logic [DATA_BITS-1:0] read_word;
  logic [DATA_BITS-1:0] fault_mask;
  logic [DATA_BITS-1:0] stored;
  logic                 write_en;
  logic                 read_en;

  assign write_en = !io_ctrl.ce_n && !io_ctrl.we_n;
  assign read_en  = !io_ctrl.ce_n && !io_ctrl.oe_n && io_ctrl.we_n;

  // stuck-at cell only shows up on reads
  assign read_word  = mem[io_addr];
  assign fault_mask = (fault_en && io_addr == fault_addr) ? (DATA_BITS'(1) << fault_bit)
                                                          : '0;
  assign stored     = (read_word & ~fault_mask) | (fault_value ? fault_mask : '0);

  assign io_data = read_en ? stored : {DATA_BITS{1'bz}};

  // latch the bus once address and data have settled
  always @(posedge write_en) begin
    #1;
    if (write_en) begin
      mem[io_addr] = io_data;
    end
  end

endmodule

// ==== tests/tb_sram_tester.sv ====
`timescale 1ns/1ps

module tb_sram_tester;

  import sram_pkg::*;
  import tester_pkg::*;

  localparam int ADDR_BITS = 6;
  localparam int DATA_BITS = 16;
  localparam int WORDS = 2 ** ADDR_BITS;
  // one start cycle plus two cycles per word in each phase
  localparam int PATTERN_CYCLES = 1 + 4 * WORDS;
  localparam int RUN_CYCLES = 6 * PATTERN_CYCLES + 1;
  localparam int MARGIN = 64;
  localparam sram_ctrl_t write_ctrl = '{we_n: 1'b0, oe_n: 1'b1, ce_n: 1'b0};

  logic                 clk;
  logic                 reset;
  test_status_t         status;
  logic [DATA_BITS-1:0] prev_read_data;
  logic [DATA_BITS-1:0] prev_expected_data;
  logic [ADDR_BITS-1:0] io_addr;
  wire  [DATA_BITS-1:0] io_data;
  sram_ctrl_t           io_ctrl;

  logic                 fault_en;
  logic [ADDR_BITS-1:0] fault_addr;
  logic [3:0]           fault_bit;
  logic                 fault_value;
  logic [31:0]          lfsr;
  logic [31:0]          delay_bits;

  // write monitor state
  logic [ADDR_BITS-1:0] next_write_addr;
  pattern_kind_e        write_kind;
  int                   patterns_written = 0;

  sram_tester #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) sram_tester_i (
    .clk               (clk),
    .reset             (reset),
    .status            (status),
    .prev_read_data    (prev_read_data),
    .prev_expected_data(prev_expected_data),
    .io_addr           (io_addr),
    .io_data           (io_data),
    .io_ctrl           (io_ctrl)
  );

  sram_model #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) sram_model_i (
    .io_addr    (io_addr),
    .io_data    (io_data),
    .io_ctrl    (io_ctrl),
    .fault_en   (fault_en),
    .fault_addr (fault_addr),
    .fault_bit  (fault_bit),
    .fault_value(fault_value)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic draw_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  // expected word for a pattern kind at one address
  function automatic logic [DATA_BITS-1:0] pattern_word(input pattern_kind_e kind,
                                                        input logic [ADDR_BITS-1:0] addr);
    logic [DATA_BITS-1:0] addr_word;
    addr_word = {{(DATA_BITS-ADDR_BITS){1'b0}}, addr};
    case (kind)
      pattern_zeros:       return 16'h0000;
      pattern_ones:        return 16'hffff;
      // even addresses start with bit 0 clear
      pattern_checker:     return addr[0] ? 16'h5555 : 16'haaaa;
      pattern_inv_checker: return addr[0] ? 16'haaaa : 16'h5555;
      pattern_addr:        return addr_word;
      default:             return ~addr_word;
    endcase
  endfunction

  function automatic test_status_t make_status(input logic done, input logic pass,
                                               input pattern_kind_e kind);
    test_status_t value;
    value.done = done;
    value.pass = pass;
    value.kind = kind;
    return value;
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_status(input string name, input test_status_t actual,
                              input test_status_t expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input logic [DATA_BITS-1:0] actual,
                            input logic [DATA_BITS-1:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_BITS-1:0] actual,
                            input logic [ADDR_BITS-1:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_ctrl(input string name, input sram_ctrl_t actual,
                            input sram_ctrl_t expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  // every write strobe goes to the next address with the current pattern word
  always @(negedge clk) begin
    if (reset) begin
      next_write_addr <= '0;
      write_kind      <= pattern_zeros;
    end else if (io_ctrl === write_ctrl) begin
      check_addr("io_addr", io_addr, next_write_addr);
      check_status("status", status, make_status(1'b0, 1'b1, write_kind));
      check_word("io_data", io_data, pattern_word(write_kind, io_addr));
      next_write_addr <= next_write_addr + 1'b1;
      if (io_addr == WORDS - 1) begin
        patterns_written <= patterns_written + 1;
        write_kind <= (write_kind == pattern_inv_addr) ? pattern_zeros
                                                       : pattern_kind_e'(write_kind + 3'd1);
      end
    end
  end

  task automatic apply_reset(input logic inject_fault);
    @(negedge clk);
    reset    = 1'b1;
    fault_en = inject_fault;
    if (inject_fault) begin
      draw_bits(ADDR_BITS, delay_bits);
      fault_addr = delay_bits[ADDR_BITS-1:0];
      draw_bits(4, delay_bits);
      fault_bit = delay_bits[3:0];
      draw_bits(1, delay_bits);
      fault_value = delay_bits[0];
    end
    repeat (4) @(negedge clk);
    reset = 1'b0;
    check_status("status", status, make_status(1'b0, 1'b1, pattern_zeros));
    check_ctrl("io_ctrl", io_ctrl, sram_ctrl_idle);
  endtask

  task automatic run_clean();
    int cycles;
    int first_pattern;
    cycles        = 0;
    first_pattern = patterns_written;
    @(negedge clk);
    while (status.done !== 1'b1) begin
      if (status.pass !== 1'b1) begin
        $display("pass dropped during a fault-free run");
        abort_run();
      end
      if (cycles > RUN_CYCLES + MARGIN) begin
        $display("timeout: no done pulse after %0d cycles", cycles);
        abort_run();
      end
      cycles++;
      @(negedge clk);
    end
    check_status("status", status, make_status(1'b1, 1'b1, pattern_zeros));
    if (patterns_written - first_pattern != 6) begin
      $display("done came after %0d patterns instead of six", patterns_written - first_pattern);
      abort_run();
    end
    @(negedge clk);
    check_status("status", status, make_status(1'b0, 1'b1, pattern_zeros));
  endtask

  task automatic run_faulty();
    int                   cycles;
    int                   fail_index;
    logic                 found;
    logic [DATA_BITS-1:0] candidate;
    logic [DATA_BITS-1:0] good_word;
    logic [DATA_BITS-1:0] bad_word;
    pattern_kind_e        halted_kind;
    apply_reset(1'b1);
    // first pattern in test order whose bit differs from the stuck value
    found      = 1'b0;
    good_word  = '0;
    fail_index = 0;
    for (int k = 0; k < 6; k++) begin
      candidate = pattern_word(pattern_kind_e'(k), fault_addr);
      if (!found && candidate[fault_bit] != fault_value) begin
        good_word  = candidate;
        fail_index = k;
        found      = 1'b1;
      end
    end
    bad_word            = good_word;
    bad_word[fault_bit] = fault_value;
    // a failure at the last address lands after the next kind is selected
    if (fault_addr == WORDS - 1) begin
      halted_kind = (fail_index == 5) ? pattern_zeros : pattern_kind_e'(fail_index + 1);
    end else begin
      halted_kind = pattern_kind_e'(fail_index);
    end
    cycles = 0;
    while (status.pass !== 1'b0) begin
      if (status.done === 1'b1) begin
        $display("done pulsed while a stuck-at fault was present");
        abort_run();
      end
      if (cycles > RUN_CYCLES + MARGIN) begin
        $display("timeout: fault at address %h bit %0d never detected", fault_addr, fault_bit);
        abort_run();
      end
      cycles++;
      @(negedge clk);
    end
    check_word("prev_expected_data", prev_expected_data, good_word);
    check_word("prev_read_data", prev_read_data, bad_word);
    // pins stay idle and status stays frozen while halted
    repeat (PATTERN_CYCLES) begin
      check_ctrl("io_ctrl", io_ctrl, sram_ctrl_idle);
      check_status("status", status, make_status(1'b0, 1'b0, halted_kind));
      @(negedge clk);
    end
  endtask

  initial begin
    reset       = 1'b1;
    fault_en    = 1'b0;
    fault_addr  = '0;
    fault_bit   = '0;
    fault_value = 1'b0;
    lfsr        = 32'h58f7;
    apply_reset(1'b0);
    run_clean();
    run_clean();
    // cut a running test short
    draw_bits(9, delay_bits);
    repeat (delay_bits[8:0] + 16) @(negedge clk);
    apply_reset(1'b0);
    repeat (3) run_faulty();
    apply_reset(1'b0);
    run_clean();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== flist.f ====
verilog/sram_pkg.sv
verilog/tester_pkg.sv
verilog/sram_controller.sv
verilog/pattern_generator.sv
verilog/sram_tester.sv
tests/sram_model.sv
tests/tb_sram_tester.sv

// ==== Bender.yml ====
package:
  name: sram_bist

sources:
  - files:
      - verilog/sram_pkg.sv
      - verilog/tester_pkg.sv
      - verilog/sram_controller.sv
      - verilog/pattern_generator.sv
      - verilog/sram_tester.sv
  - target: test
    files:
      - tests/sram_model.sv
      - tests/tb_sram_tester.sv
